// File: common/cdc_pkg.sv
// Clock-domain gating controller shared constants, widths and state encoding
package cdc_pkg;

    // ------------------------------
    // Sizing
    // ------------------------------

    // Number of agents that may request the main clock
    localparam int NUM_AGENTS = 4;

    // Consecutive idle cycles seen while ON before the clock is gated again
    localparam int IDLE_HOLDOFF = 8;

    // Counter must be able to hold the value IDLE_HOLDOFF itself
    localparam int IDLE_CNT_W = $clog2(IDLE_HOLDOFF + 1);

    // ------------------------------
    // Types
    // ------------------------------

    // One bit per agent
    // Used for the raw requests, the synchronized requests and the mask
    typedef logic [NUM_AGENTS-1:0] agent_vec_t;

    // Idle holdoff counter value
    typedef logic [IDLE_CNT_W-1:0] idle_cnt_t;

    // Controller state
    // OFF          clock gated, enable low, acknowledge low
    // UNGATE_WAIT  enable raised, waiting for the acknowledge to rise
    // ON           clock running, idle holdoff armed
    // GATE_WAIT    enable dropped, waiting for the acknowledge to fall
    typedef enum logic [1:0] {
        OFF         = 2'b00,
        UNGATE_WAIT = 2'b01,
        ON          = 2'b10,
        GATE_WAIT   = 2'b11
    } cdc_state_t;

endpackage

// File: cdc/cdc_main_cg.sv
// Main clock gate with double-synchronized enable, echoed acknowledge and latch-based gate
`timescale 1ns/1ps

module cdc_main_cg (
    // Main clock domain
    input  logic clock,
    input  logic rst_n,

    // Enable from the controller, a level
    input  logic gclock_enable,

    // Test control, forces the gated clock on
    input  logic fscan_clkungate,

    // Gated version of clock
    output logic gclock,

    // Enable as seen by the gate itself
    output logic gclock_enable_final,

    // Final enable echoed back to the controller
    output logic gclock_enable_ack
);

    // ------------------------------
    // Enable and acknowledge syncs
    // ------------------------------

    // Two stages each
    // Bit 0 is the capture stage, bit 1 the output stage
    logic [1:0] en_sync;
    logic [1:0] ack_sync;

    // Both chains reset low, so the clock starts gated
    // Enable reaches the gate 2 edges after the controller raises it
    // and comes back as the acknowledge 2 edges after that
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            en_sync  <= 2'b00;
            ack_sync <= 2'b00;
        end else begin
            en_sync  <= {en_sync[0], gclock_enable};
            ack_sync <= {ack_sync[0], en_sync[1]};
        end
    end

    assign gclock_enable_final = en_sync[1];
    assign gclock_enable_ack   = ack_sync[1];

    // ------------------------------
    // Clock gate
    // ------------------------------

    // Gate enable, functional or scan
    logic cg_en;

    // Latched copy of the gate enable
    logic cg_latch;

    assign cg_en = gclock_enable_final | fscan_clkungate;

    // Transparent while clock is low
    // Holds through the high phase so gclock never glitches
    always_latch begin
        if (!clock) begin
            cg_latch = cg_en;
        end
    end

    // AND gate on the clock
    // Enable changes only after a rising edge, when the latch is closed
    assign gclock = clock & cg_latch;

endmodule

// File: cdc/cdc_fsm.sv
// Controller FSM that sequences clock ungating and gating against the gate acknowledge
`timescale 1ns/1ps

module cdc_fsm
    import cdc_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,

    // Combined, masked agent request
    input  logic       any_req,

    // One-cycle pulse when the idle holdoff runs out
    input  logic       idle_expired,

    // Echo of the enable from the gate unit
    input  logic       gclock_enable_ack,

    // Registered enable to the gate unit
    output logic       gclock_enable,

    // High in ON, to the idle timer
    output logic       clock_on,

    // High in ON, to the outside
    output logic       clock_active,

    // Current state for observation
    output cdc_state_t cdc_state
);

    // ------------------------------
    // State register
    // ------------------------------

    cdc_state_t state;
    cdc_state_t state_nxt;

    // Single flop decoding ON, shared by both outputs
    logic       on_q;

    // ------------------------------
    // Next state
    // ------------------------------

    // Each wait state leaves only once the acknowledge matches the enable
    // Enable is therefore never changed while a sync is in flight
    always_comb begin
        state_nxt = state;
        unique case (state)
            OFF: begin
                // Request seen, raise the enable
                if (any_req) begin
                    state_nxt = UNGATE_WAIT;
                end
            end
            UNGATE_WAIT: begin
                // Gate has seen the enable
                if (gclock_enable_ack) begin
                    state_nxt = ON;
                end
            end
            ON: begin
                // Idle for the full holdoff
                if (idle_expired) begin
                    state_nxt = GATE_WAIT;
                end
            end
            GATE_WAIT: begin
                // Gate has dropped the enable
                // A request that came in meanwhile is picked up from OFF
                if (!gclock_enable_ack) begin
                    state_nxt = OFF;
                end
            end
            default: begin
                state_nxt = OFF;
            end
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------

    // Outputs decoded from the next state so they line up with the state
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state         <= OFF;
            gclock_enable <= 1'b0;
            on_q          <= 1'b0;
        end else begin
            state         <= state_nxt;
            gclock_enable <= (state_nxt == UNGATE_WAIT) || (state_nxt == ON);
            on_q          <= (state_nxt == ON);
        end
    end

    assign clock_on     = on_q;
    assign clock_active = on_q;
    assign cdc_state    = state;

endmodule

// File: hw/cdc_req_collect.sv
// Request collector that synchronizes, masks and ORs the agents' clock requests
`timescale 1ns/1ps

module cdc_req_collect
    import cdc_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,

    // Raw agent requests, asynchronous levels
    input  agent_vec_t clk_req,

    // Quasi-static mask, a 1 blocks that agent
    input  agent_vec_t req_mask,

    // Any unmasked synchronized request
    output logic       any_req
);

    // ------------------------------
    // Request synchronizer
    // ------------------------------

    // First stage may go metastable
    agent_vec_t req_meta;

    // Second stage, safe to use in clock domain
    agent_vec_t req_sync;

    // Both stages reset low, so no agent requests out of reset
    // A request change shows up in req_sync 2 edges later
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_meta <= '0;
            req_sync <= '0;
        end else begin
            req_meta <= clk_req;
            req_sync <= req_meta;
        end
    end

    // ------------------------------
    // Mask and combine
    // ------------------------------

    // Mask is static enough to use directly
    // A mask change acts in the same cycle
    assign any_req = |(req_sync & ~req_mask);

endmodule

// File: hw/cdc_idle_timer.sv
// Idle holdoff timer that pulses once the running clock has gone unrequested long enough
`timescale 1ns/1ps

module cdc_idle_timer
    import cdc_pkg::*;
(
    input  logic clock,
    input  logic rst_n,

    // Controller is in ON
    input  logic clock_on,

    // Any unmasked request
    input  logic any_req,

    // One-cycle pulse, start gating
    output logic idle_expired
);

    // ------------------------------
    // Idle counter
    // ------------------------------

    idle_cnt_t idle_cnt;
    idle_cnt_t idle_cnt_inc;

    assign idle_cnt_inc = idle_cnt + idle_cnt_t'(1);

    // Short request gaps restart the count, giving hysteresis
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            idle_cnt     <= '0;
            idle_expired <= 1'b0;
        end else if (!clock_on || any_req) begin
            // Clock off or requested, nothing to time
            idle_cnt     <= '0;
            idle_expired <= 1'b0;
        end else if (idle_cnt_inc == idle_cnt_t'(IDLE_HOLDOFF)) begin
            // Holdoff reached, pulse and restart
            idle_cnt     <= '0;
            idle_expired <= 1'b1;
        end else begin
            idle_cnt     <= idle_cnt_inc;
            idle_expired <= 1'b0;
        end
    end

endmodule

// File: hw/cdc_top.sv
// Clock-domain gating controller top level joining collector, timer, FSM and gate unit
`timescale 1ns/1ps

module cdc_top
    import cdc_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,

    // Agent interface
    input  agent_vec_t clk_req,
    input  agent_vec_t req_mask,

    // Test control
    input  logic       fscan_clkungate,

    // Gated clock and status
    output logic       gclock,
    output logic       clock_active,
    output cdc_state_t cdc_state
);

    // ------------------------------
    // Internal wires
    // ------------------------------

    logic any_req;
    logic idle_expired;
    logic clock_on;
    logic gclock_enable;
    logic gclock_enable_ack;

    // Request synchronizer and mask
    cdc_req_collect u_req (
        .clock    (clock),
        .rst_n    (rst_n),
        .clk_req  (clk_req),
        .req_mask (req_mask),
        .any_req  (any_req)
    );

    // Idle holdoff
    cdc_idle_timer u_idle (
        .clock        (clock),
        .rst_n        (rst_n),
        .clock_on     (clock_on),
        .any_req      (any_req),
        .idle_expired (idle_expired)
    );

    // Controller
    cdc_fsm u_fsm (
        .clock             (clock),
        .rst_n             (rst_n),
        .any_req           (any_req),
        .idle_expired      (idle_expired),
        .gclock_enable_ack (gclock_enable_ack),
        .gclock_enable     (gclock_enable),
        .clock_on          (clock_on),
        .clock_active      (clock_active),
        .cdc_state         (cdc_state)
    );

    // Gate unit, final enable only observed inside
    cdc_main_cg u_cg (
        .clock               (clock),
        .rst_n               (rst_n),
        .gclock_enable       (gclock_enable),
        .fscan_clkungate     (fscan_clkungate),
        .gclock              (gclock),
        .gclock_enable_final (),
        .gclock_enable_ack   (gclock_enable_ack)
    );

endmodule

// File: sim/cdc_tb.sv
// Testbench for the clock gating controller, table rows, random rows and gclock edge windows
`timescale 1ns/1ps

module cdc_tb
    import cdc_pkg::*;
();

    // ------------------------------
    // Constants and row format
    // ------------------------------

    localparam int SETTLE_TIMEOUT = 40;
    localparam int STABLE_CYCLES  = IDLE_HOLDOFF + 4;
    localparam int WINDOW_CYCLES  = 16;
    localparam int NUM_ROWS       = 13;
    localparam int NUM_RANDOM     = 24;

    // One stimulus row
    // gap is the number of cycles all requests drop before the row's requests return
    // steady means the state must not move while the row is applied
    typedef struct packed {
        agent_vec_t req;
        agent_vec_t mask;
        logic       scan;
        int         gap;
        logic       steady;
        logic       exp_active;
        logic       exp_toggle;
    } row_t;

    // ------------------------------
    // DUT and clock
    // ------------------------------

    logic       clock = 1'b0;
    logic       rst_n;
    agent_vec_t clk_req;
    agent_vec_t req_mask;
    logic       fscan_clkungate;
    logic       gclock;
    logic       clock_active;
    cdc_state_t cdc_state;

    int   gedge_cnt    = 0;
    int   value_errs   = 0;
    int   timeout_errs = 0;
    row_t rows [NUM_ROWS];

    cdc_top u_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .clk_req         (clk_req),
        .req_mask        (req_mask),
        .fscan_clkungate (fscan_clkungate),
        .gclock          (gclock),
        .clock_active    (clock_active),
        .cdc_state       (cdc_state)
    );

    // 8 ns period
    always #4 clock = ~clock;

    // Running count of gated clock rising edges, windows take differences
    always @(posedge gclock) begin
        gedge_cnt <= gedge_cnt + 1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic row_t make_row(input agent_vec_t req, input agent_vec_t mask,
                                      input logic scan, input int gap, input logic steady,
                                      input logic exp_active, input logic exp_toggle);
        row_t r;
        r.req        = req;
        r.mask       = mask;
        r.scan       = scan;
        r.gap        = gap;
        r.steady     = steady;
        r.exp_active = exp_active;
        r.exp_toggle = exp_toggle;
        return r;
    endfunction

    // Xorshift32 step
    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Clock should run when at least one requesting agent is not blocked
    function automatic logic unmasked_request(input agent_vec_t req, input agent_vec_t mask);
        logic found;
        found = 1'b0;
        for (int a = 0; a < NUM_AGENTS; a++) begin
            if (req[a] && !mask[a]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_state_held(input cdc_state_t held, input int idx);
        assert (cdc_state == held) else begin
            value_errs++;
            $display("Fail row %0d: cdc_state expected %h got %h", idx, held, cdc_state);
        end
    endtask

    // Drive one row, wait for the controller to settle, then check level and gclock
    task automatic apply_row(input row_t r, input int idx);
        cdc_state_t start_state;
        cdc_state_t last_state;
        cdc_state_t exp_state;
        int         stable;
        int         cycles;
        int         edges_start;
        int         edges;
        bit         settled;
        start_state = cdc_state;
        last_state  = cdc_state;
        exp_state   = r.exp_active ? ON : OFF;
        stable      = 0;
        cycles      = 0;
        settled     = 1'b0;

        @(negedge clock);
        req_mask        = r.mask;
        fscan_clkungate = r.scan;
        clk_req         = (r.gap > 0) ? '0 : r.req;

        // Short request gap, shorter than the idle holdoff
        for (int g = 0; g < r.gap; g++) begin
            @(negedge clock);
            if (r.steady) begin
                check_state_held(start_state, idx);
            end
        end
        clk_req = r.req;

        // Settled means ON or OFF for STABLE_CYCLES samples in a row
        while (!settled && cycles < SETTLE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            if (r.steady) begin
                check_state_held(start_state, idx);
            end
            if ((cdc_state == ON || cdc_state == OFF) && cdc_state == last_state) begin
                stable++;
            end else if (cdc_state == ON || cdc_state == OFF) begin
                stable = 1;
            end else begin
                stable = 0;
            end
            last_state = cdc_state;
            settled    = (stable >= STABLE_CYCLES);
        end

        assert (settled) else begin
            timeout_errs++;
            $display("Row %0d: controller did not settle in ON or OFF within %0d cycles",
                     idx, SETTLE_TIMEOUT);
        end
        assert (clock_active == r.exp_active) else begin
            value_errs++;
            $display("Fail row %0d: clock_active expected %h got %h",
                     idx, r.exp_active, clock_active);
        end
        assert (cdc_state == exp_state) else begin
            value_errs++;
            $display("Fail row %0d: cdc_state expected %h got %h", idx, exp_state, cdc_state);
        end

        // Edge window, full rate when running
        edges_start = gedge_cnt;
        repeat (WINDOW_CYCLES) @(negedge clock);
        edges = gedge_cnt - edges_start;
        assert (edges == (r.exp_toggle ? WINDOW_CYCLES : 0)) else begin
            value_errs++;
            $display("Fail row %0d: gclock edges expected %h got %h",
                     idx, (r.exp_toggle ? WINDOW_CYCLES : 0), edges);
        end
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        logic [31:0] seed;
        agent_vec_t  rand_req;
        agent_vec_t  rand_mask;
        logic        rand_scan;
        logic        rand_active;
        clk_req         = '0;
        req_mask        = '0;
        fscan_clkungate = 1'b0;
        rst_n           = 1'b0;

        //                  req      mask     scan  gap steady active toggle
        // Quiet after reset
        rows[0]  = make_row(4'b0000, 4'b0000, 1'b0, 0, 1'b1, 1'b0, 1'b0);
        // Single unmasked agent
        rows[1]  = make_row(4'b0001, 4'b0000, 1'b0, 0, 1'b0, 1'b1, 1'b1);
        // All requests gone, idle gating
        rows[2]  = make_row(4'b0000, 4'b0000, 1'b0, 0, 1'b0, 1'b0, 1'b0);
        // Requests on masked agents only
        rows[3]  = make_row(4'b0110, 4'b0110, 1'b0, 0, 1'b1, 1'b0, 1'b0);
        // Agent 1 unmasked
        rows[4]  = make_row(4'b0110, 4'b0100, 1'b0, 0, 1'b0, 1'b1, 1'b1);
        // Gap shorter than the holdoff keeps the clock on
        rows[5]  = make_row(4'b0110, 4'b0100, 1'b0, 4, 1'b1, 1'b1, 1'b1);
        rows[6]  = make_row(4'b0000, 4'b0000, 1'b0, 0, 1'b0, 1'b0, 1'b0);
        // Scan ungate alone
        rows[7]  = make_row(4'b0000, 4'b0000, 1'b1, 0, 1'b1, 1'b0, 1'b1);
        rows[8]  = make_row(4'b1000, 4'b0000, 1'b1, 0, 1'b0, 1'b1, 1'b1);
        rows[9]  = make_row(4'b0000, 4'b0000, 1'b0, 0, 1'b0, 1'b0, 1'b0);
        // Everything masked
        rows[10] = make_row(4'b1111, 4'b1111, 1'b0, 0, 1'b1, 1'b0, 1'b0);
        rows[11] = make_row(4'b1111, 4'b0111, 1'b0, 0, 1'b0, 1'b1, 1'b1);
        rows[12] = make_row(4'b0000, 4'b0000, 1'b0, 0, 1'b0, 1'b0, 1'b0);

        // Three reset cycles
        repeat (3) @(negedge clock);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i], i);
        end

        // Random rows, scan ungate about one row in four
        seed = 32'h4c9787fa;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            seed        = next_rand(seed);
            rand_req    = seed[NUM_AGENTS-1:0];
            rand_mask   = seed[2*NUM_AGENTS-1:NUM_AGENTS];
            rand_scan   = (seed[9:8] == 2'b11);
            rand_active = unmasked_request(rand_req, rand_mask);
            apply_row(make_row(rand_req, rand_mask, rand_scan, 0, 1'b0,
                               rand_active, rand_active | rand_scan), NUM_ROWS + i);
        end

        $display("Checks done: %0d value errors, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/cdc_pkg.sv
cdc/cdc_main_cg.sv
cdc/cdc_fsm.sv
hw/cdc_req_collect.sv
hw/cdc_idle_timer.sv
hw/cdc_top.sv
sim/cdc_tb.sv

// File: run.sh
#!/bin/sh
# Build the clock gating controller testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cdc_tb \
    -f verilog.f \
    -o cdc_sim > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/cdc_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$SIM_LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "RESULT: PASS" "$SIM_LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
